// File: spi_pkg.sv
package spi_pkg;

  // ======================================================================
  // Widths
  // ======================================================================
  localparam int DATA_W  = 32;  // Bus data word
  localparam int BYTE_W  = 8;   // One SPI transfer
  localparam int SEL_W   = 4;   // Byte-lane selects
  localparam int SPEED_W = 2;

  // One-bit word addresses of the registers
  localparam logic ADDR_DATA = 1'b0;
  localparam logic ADDR_CTRL = 1'b1;

  // ======================================================================
  // Configuration byte and status word fields
  // ======================================================================
  localparam int CONF_SPEED_LSB = 0;
  localparam int CONF_CPOL_BIT  = 2;
  localparam int CONF_CPHA_BIT  = 3;

  localparam int STAT_RX_BIT  = 0;  // Receive-ready
  localparam int STAT_TX_BIT  = 1;  // Transmit-busy
  localparam int STAT_WP_BIT  = 2;
  localparam int STAT_IRQ_BIT = 3;

  // Slave selects are active low, so all deselected
  localparam logic [BYTE_W-1:0] SELECTS_RESET = 8'hFF;

  // ======================================================================
  // Serial clock rate
  // ======================================================================
  // Fastest SCLK is a quarter of the nominal 100 MHz reference
  localparam int unsigned SCLK_MAX_HZ = 25_000_000;

  // Divider counter with room for the slowest speed at any sane clock rate
  localparam int DIV_CNT_W = 16;
  typedef logic [DIV_CNT_W-1:0] div_cnt_t;

endpackage

// File: spi_clk_div.sv
`timescale 1ns/1ns

module spi_clk_div #(
  parameter int unsigned CLK_FREQ = 100000000
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        en_i,
  input  logic [spi_pkg::SPEED_W-1:0] speed_i,
  output logic                        tick_o
);
  import spi_pkg::*;

  // Base half period in system clocks, never below one
  localparam int unsigned BASE_RAW  = CLK_FREQ / (2 * SCLK_MAX_HZ);
  localparam int unsigned BASE_HALF = (BASE_RAW < 1) ? 1 : BASE_RAW;

  div_cnt_t half_period;
  div_cnt_t terminal;
  div_cnt_t cnt_q;

  // Each speed step doubles the half period
  always_comb begin
    half_period = div_cnt_t'(BASE_HALF) << speed_i;
    terminal    = half_period - 1'b1;
  end

  assign tick_o = en_i && (cnt_q == terminal);

  // ======================================================================
  // Half-period counter
  // ======================================================================
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (!en_i) begin
      cnt_q <= '0;              // Held clear so a new transfer starts fresh
    end else if (cnt_q == terminal) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

// File: spi_xcvr.sv
`timescale 1ns/1ns

module spi_xcvr #(
  parameter int unsigned CLK_FREQ = 100000000
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       start_i,
  input  logic [spi_pkg::BYTE_W-1:0] conf_i,
  input  logic [spi_pkg::BYTE_W-1:0] tx_i,
  input  logic                       miso_i,
  output logic [spi_pkg::BYTE_W-1:0] rx_o,
  output logic                       done_o,
  output logic                       sclk_o,
  output logic                       mosi_o
);
  import spi_pkg::*;

  // Two SCLK edges per bit
  localparam int EDGES  = 2 * BYTE_W;
  localparam int EDGE_W = $clog2(EDGES);

  logic               active_q;
  logic               cpha_q;
  logic [SPEED_W-1:0] speed_q;
  logic               sclk_q;
  logic [EDGE_W-1:0]  edge_cnt;
  logic [BYTE_W-1:0]  tx_sr;
  logic [BYTE_W-1:0]  rx_sr;
  logic [BYTE_W-1:0]  rx_next;
  logic               tick;
  logic               sample_edge;
  logic               last_edge;

  spi_clk_div #(
    .CLK_FREQ(CLK_FREQ)
  ) u_clk_div (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .en_i   (active_q),
    .speed_i(speed_q),
    .tick_o (tick)
  );

  // Even edge count is a leading edge; cpha picks which kind samples
  assign sample_edge = (edge_cnt[0] == cpha_q);
  assign last_edge   = (edge_cnt == EDGE_W'(EDGES - 1));
  assign rx_next     = sample_edge ? {rx_sr[BYTE_W-2:0], miso_i} : rx_sr;

  // Idle clock follows the configured polarity without delay
  assign sclk_o = active_q ? sclk_q : conf_i[CONF_CPOL_BIT];

  // ======================================================================
  // Transfer control
  // ======================================================================
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      active_q <= 1'b0;
      cpha_q   <= 1'b0;
      speed_q  <= '0;
      sclk_q   <= 1'b0;
      edge_cnt <= '0;
      done_o   <= 1'b0;
      mosi_o   <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        active_q <= 1'b1;
        cpha_q   <= conf_i[CONF_CPHA_BIT];
        speed_q  <= conf_i[CONF_SPEED_LSB +: SPEED_W];
        sclk_q   <= conf_i[CONF_CPOL_BIT];
        edge_cnt <= '0;
        mosi_o   <= tx_i[BYTE_W-1];   // MSB first and ready before edge one
      end else if (active_q && tick) begin
        sclk_q   <= ~sclk_q;
        edge_cnt <= edge_cnt + 1'b1;
        if (!sample_edge) begin
          mosi_o <= tx_sr[BYTE_W-1];
        end
        if (last_edge) begin
          active_q <= 1'b0;
          done_o   <= 1'b1;
        end
      end
    end
  end

  // Shift registers and received byte
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      // With cpha 0 bit 7 is already on mosi, so skip it here
      tx_sr <= conf_i[CONF_CPHA_BIT] ? tx_i : {tx_i[BYTE_W-2:0], 1'b0};
    end else if (active_q && tick) begin
      rx_sr <= rx_next;
      if (!sample_edge) begin
        tx_sr <= {tx_sr[BYTE_W-2:0], 1'b0};
      end
      if (last_edge) begin
        rx_o <= rx_next;                // Last sample included
      end
    end
  end

endmodule

// File: spi_master.sv
`timescale 1ns/1ns

module spi_master #(
  parameter int unsigned CLK_FREQ = 100000000
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       cyc_i,
  input  logic                       stb_i,
  input  logic                       we_i,
  input  logic                       adr_i,
  input  logic [spi_pkg::SEL_W-1:0]  sel_i,
  input  logic [spi_pkg::DATA_W-1:0] dat_i,
  input  logic                       miso_i,
  input  logic                       codec_irq_i,
  input  logic                       wp_i,
  output logic [spi_pkg::DATA_W-1:0] dat_o,
  output logic                       ack_o,
  output logic [spi_pkg::BYTE_W-1:0] selects_o,
  output logic                       mosi_o,
  output logic                       sclk_o
);
  import spi_pkg::*;

  localparam int SEL_LANE  = 3;  // Byte lane of the slave selects
  localparam int CONF_LANE = 2;

  typedef enum logic {
    ST_IDLE,
    ST_DONE
  } state_t;

  state_t            state_q, state_d;
  logic [BYTE_W-1:0] selects_d;
  logic [BYTE_W-1:0] conf_q, conf_d;
  logic [BYTE_W-1:0] rx_byte_q, rx_byte_d;
  logic [DATA_W-1:0] dat_d;
  logic [DATA_W-1:0] status_word;
  logic              tx_busy_q, tx_busy_d;
  logic              rx_ready_q, rx_ready_d;
  logic              tx_start;
  logic              tx_done;
  logic [BYTE_W-1:0] rx_in;

  assign ack_o = (state_q == ST_DONE);

  // Control and status read word
  always_comb begin
    status_word = '0;
    status_word[SEL_LANE*BYTE_W +: BYTE_W]  = selects_o;
    status_word[CONF_LANE*BYTE_W +: BYTE_W] = conf_q;
    status_word[STAT_IRQ_BIT] = codec_irq_i;   // Live level
    status_word[STAT_WP_BIT]  = wp_i;
    status_word[STAT_TX_BIT]  = tx_busy_q;
    status_word[STAT_RX_BIT]  = rx_ready_q;
  end

  // ======================================================================
  // Bus FSM and register decode
  // ======================================================================
  always_comb begin
    state_d    = state_q;
    selects_d  = selects_o;
    conf_d     = conf_q;
    rx_byte_d  = rx_byte_q;
    dat_d      = dat_o;
    tx_busy_d  = tx_busy_q;
    rx_ready_d = rx_ready_q;
    tx_start   = 1'b0;

    case (state_q)
      ST_IDLE: begin
        if (cyc_i && stb_i) begin
          state_d = ST_DONE;          // Every request acked next cycle
          if (adr_i == ADDR_DATA) begin
            if (we_i) begin
              if (!tx_busy_q) begin
                tx_start  = 1'b1;
                tx_busy_d = 1'b1;
              end
            end else begin
              dat_d      = DATA_W'(rx_byte_q);
              rx_ready_d = 1'b0;
            end
          end else if (we_i) begin
            if (sel_i[SEL_LANE]) begin
              selects_d = dat_i[SEL_LANE*BYTE_W +: BYTE_W];
            end
            if (sel_i[CONF_LANE]) begin
              conf_d = dat_i[CONF_LANE*BYTE_W +: BYTE_W];
            end
          end else begin
            dat_d = status_word;
          end
        end
      end
      default: state_d = ST_IDLE;     // Bus ignored while acking
    endcase

    // Completion wins over a same-cycle data read
    if (tx_done && tx_busy_q) begin
      rx_byte_d  = rx_in;
      tx_busy_d  = 1'b0;
      rx_ready_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= ST_IDLE;
      selects_o  <= SELECTS_RESET;
      conf_q     <= '0;
      rx_byte_q  <= '0;
      dat_o      <= '0;
      tx_busy_q  <= 1'b0;
      rx_ready_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      selects_o  <= selects_d;
      conf_q     <= conf_d;
      rx_byte_q  <= rx_byte_d;
      dat_o      <= dat_d;
      tx_busy_q  <= tx_busy_d;
      rx_ready_q <= rx_ready_d;
    end
  end

  spi_xcvr #(
    .CLK_FREQ(CLK_FREQ)
  ) u_xcvr (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .start_i(tx_start),
    .conf_i (conf_q),
    .tx_i   (dat_i[BYTE_W-1:0]),
    .miso_i (miso_i),
    .rx_o   (rx_in),
    .done_o (tx_done),
    .sclk_o (sclk_o),
    .mosi_o (mosi_o)
  );

endmodule

// File: spi_top.sv
`timescale 1ns/1ns

module spi_top #(
  parameter int unsigned CLK_FREQ = 100000000
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       cyc_i,
  input  logic                       stb_i,
  input  logic                       we_i,
  input  logic                       adr_i,
  input  logic [spi_pkg::SEL_W-1:0]  sel_i,
  input  logic [spi_pkg::DATA_W-1:0] dat_i,
  input  logic                       miso_i,
  input  logic                       codec_irq_i,
  input  logic                       wp_i,
  output logic [spi_pkg::DATA_W-1:0] dat_o,
  output logic                       ack_o,
  output logic [spi_pkg::BYTE_W-1:0] selects_o,
  output logic                       mosi_o,
  output logic                       sclk_o
);

  // Register slave with its transceiver underneath
  spi_master #(
    .CLK_FREQ(CLK_FREQ)
  ) u_master (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cyc_i      (cyc_i),
    .stb_i      (stb_i),
    .we_i       (we_i),
    .adr_i      (adr_i),
    .sel_i      (sel_i),
    .dat_i      (dat_i),
    .miso_i     (miso_i),
    .codec_irq_i(codec_irq_i),
    .wp_i       (wp_i),
    .dat_o      (dat_o),
    .ack_o      (ack_o),
    .selects_o  (selects_o),
    .mosi_o     (mosi_o),
    .sclk_o     (sclk_o)
  );

endmodule

// File: tb_spi_slave.sv
`timescale 1ns/1ns

module tb_spi_slave (
  input  logic       sclk_i,
  input  logic       mosi_i,
  input  logic       cpol_i,
  input  logic       cpha_i,
  input  logic       load_i,
  input  logic [7:0] reply_i,
  output logic       miso_o,
  output logic [7:0] rx_byte_o
);
  import spi_pkg::*;

  logic [BYTE_W-1:0] tx_sr = '0;
  logic              armed = 1'b0;  // Only follows sclk during one transfer
  logic              leading;
  int                edges = 0;

  initial begin
    miso_o    = 1'b0;
    rx_byte_o = '0;
  end

  // ======================================================================
  // Edge-driven slave, any of the four modes
  // ======================================================================
  always @(posedge load_i or sclk_i) begin
    if (load_i) begin
      armed     = 1'b1;
      edges     = 0;
      rx_byte_o = '0;
      if (cpha_i) begin
        tx_sr = reply_i;                  // First bit goes out on the leading edge
      end else begin
        miso_o = reply_i[BYTE_W-1];       // MSB valid before the first edge
        tx_sr  = reply_i << 1;
      end
    end else if (armed) begin
      leading = (sclk_i != cpol_i);
      if (leading ^ cpha_i) begin
        rx_byte_o = {rx_byte_o[BYTE_W-2:0], mosi_i};
      end else begin
        miso_o = tx_sr[BYTE_W-1];
        tx_sr  = tx_sr << 1;
      end
      edges++;
      if (edges == 2 * BYTE_W) begin
        armed = 1'b0;
      end
    end
  end

endmodule

// File: tb_spi_top.sv
`timescale 1ns/1ns

module tb_spi_top;
  import spi_pkg::*;

  localparam int unsigned TB_CLK_FREQ = 100_000_000;  // Base half period of 2 clocks
  localparam int CYCLES_PER_TEST = 200;
  localparam int CONF_LANE       = 2;                  // Config byte lane in the CSR

  logic              clk = 1'b0;
  logic              rst;
  logic              cyc;
  logic              stb;
  logic              we;
  logic              adr;
  logic [SEL_W-1:0]  sel;
  logic [DATA_W-1:0] dat_wr;
  logic [DATA_W-1:0] dat_rd;
  logic              ack;
  logic [BYTE_W-1:0] selects;
  logic              mosi;
  logic              sclk;
  logic              miso;
  logic              codec_irq;
  logic              wp;
  logic              slv_load;
  logic [BYTE_W-1:0] slv_reply;
  logic              slv_cpol;
  logic              slv_cpha;
  logic [BYTE_W-1:0] slv_rx;

  // Test table from the data file
  string             t_name[$];
  string             t_op[$];
  logic              t_adr[$];
  logic [SEL_W-1:0]  t_sel[$];
  logic [DATA_W-1:0] t_dat[$];
  logic [BYTE_W-1:0] t_reply[$];
  logic [DATA_W-1:0] t_exp[$];

  logic [BYTE_W-1:0] conf_model;   // Config byte as last written
  int                seed = 32'h917a4558;
  int                cycle_count = 0;
  int                cycle_limit = 0;

  always #50 clk = ~clk;

  spi_top #(
    .CLK_FREQ(TB_CLK_FREQ)
  ) u_dut (
    .clk_i      (clk),
    .rst_i      (rst),
    .cyc_i      (cyc),
    .stb_i      (stb),
    .we_i       (we),
    .adr_i      (adr),
    .sel_i      (sel),
    .dat_i      (dat_wr),
    .miso_i     (miso),
    .codec_irq_i(codec_irq),
    .wp_i       (wp),
    .dat_o      (dat_rd),
    .ack_o      (ack),
    .selects_o  (selects),
    .mosi_o     (mosi),
    .sclk_o     (sclk)
  );

  tb_spi_slave u_slave (
    .sclk_i   (sclk),
    .mosi_i   (mosi),
    .cpol_i   (slv_cpol),
    .cpha_i   (slv_cpha),
    .load_i   (slv_load),
    .reply_i  (slv_reply),
    .miso_o   (miso),
    .rx_byte_o(slv_rx)
  );

  // ======================================================================
  // Reporting and compares
  // ======================================================================
  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      report_failure($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_byte(input string name, input logic [BYTE_W-1:0] exp,
                            input logic [BYTE_W-1:0] act);
    if (act !== exp) begin
      report_failure($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
    end
  endtask

  // ======================================================================
  // Bus and slave helpers
  // ======================================================================
  task automatic bus_cycle(input logic wr, input logic addr, input logic [SEL_W-1:0] lanes,
                           input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
    int waits;
    waits = 0;
    @(posedge clk);
    cyc    <= 1'b1;
    stb    <= 1'b1;
    we     <= wr;
    adr    <= addr;
    sel    <= lanes;
    dat_wr <= wdata;
    @(negedge clk);
    while (ack !== 1'b1) begin
      waits++;
      if (waits >= 4) begin
        report_failure("Bus error: no acknowledge within 4 cycles");
      end
      @(negedge clk);
    end
    rdata = dat_rd;               // Valid in the ack cycle
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  // Drives fresh irq and wp levels, returns them placed in a status word
  task automatic read_status(output logic [DATA_W-1:0] word, output logic [DATA_W-1:0] pins);
    int r;
    r = $random(seed);
    @(posedge clk);
    codec_irq <= r[0];
    wp        <= r[1];
    bus_cycle(1'b0, ADDR_CTRL, '1, '0, word);
    pins = '0;
    pins[STAT_IRQ_BIT] = r[0];
    pins[STAT_WP_BIT]  = r[1];
  endtask

  task automatic wait_idle(output logic [DATA_W-1:0] word);
    logic [DATA_W-1:0] pins;
    read_status(word, pins);
    while (word[STAT_TX_BIT]) begin
      read_status(word, pins);
    end
  endtask

  task automatic arm_slave(input logic [BYTE_W-1:0] reply);
    @(posedge clk);
    slv_reply <= reply;
    slv_cpol  <= conf_model[CONF_CPOL_BIT];
    slv_cpha  <= conf_model[CONF_CPHA_BIT];
    @(posedge clk);
    slv_load <= 1'b1;
    @(posedge clk);
    slv_load <= 1'b0;
  endtask

  // ======================================================================
  // Data file and test sequencing
  // ======================================================================
  task automatic load_tests();
    int                fd;
    int                n;
    string             tok;
    string             op;
    logic              a;
    logic [SEL_W-1:0]  s;
    logic [DATA_W-1:0] d;
    logic [BYTE_W-1:0] r;
    logic [DATA_W-1:0] e;
    logic [8*120-1:0]  rest;
    fd = $fopen("spi_input.txt", "r");
    if (fd == 0) begin
      report_failure("Cannot open the data file spi_input.txt");
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok[0] == "#") begin
        n = $fgets(rest, fd);     // Column notes
      end else begin
        n = $fscanf(fd, "%s %h %h %h %h %h", op, a, s, d, r, e);
        if (n != 6) begin
          report_failure({"Malformed data file line for test ", tok});
        end
        t_name.push_back(tok);
        t_op.push_back(op);
        t_adr.push_back(a);
        t_sel.push_back(s);
        t_dat.push_back(d);
        t_reply.push_back(r);
        t_exp.push_back(e);
      end
    end
    $fclose(fd);
  endtask

  task automatic run_test(input int i);
    string             name;
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] pins;
    logic [DATA_W-1:0] rdata;
    name = t_name[i];
    if (t_op[i] == "W") begin
      bus_cycle(1'b1, t_adr[i], t_sel[i], t_dat[i], word);
      if (t_adr[i] == ADDR_CTRL && t_sel[i][CONF_LANE]) begin
        conf_model = t_dat[i][CONF_LANE*BYTE_W +: BYTE_W];
      end
      @(negedge clk);
      check_byte({name, " selects"}, t_exp[i][BYTE_W-1:0], selects);
      check_bit({name, " sclk idle"}, conf_model[CONF_CPOL_BIT], sclk);
    end else if (t_op[i] == "R") begin
      if (t_adr[i] == ADDR_CTRL) begin
        read_status(word, pins);
        check_word(name, t_exp[i] | pins, word);
      end else begin
        bus_cycle(1'b0, ADDR_DATA, t_sel[i], '0, word);
        check_word(name, t_exp[i], word);
      end
    end else if (t_op[i] == "X" || t_op[i] == "B") begin
      arm_slave(t_reply[i]);
      bus_cycle(1'b1, ADDR_DATA, t_sel[i], t_dat[i], word);
      if (t_op[i] == "B") begin
        read_status(word, pins);
        check_bit({name, " busy during transfer"}, 1'b1, word[STAT_TX_BIT]);
        bus_cycle(1'b1, ADDR_DATA, t_sel[i], ~t_dat[i], word);  // Must be dropped
      end
      wait_idle(word);
      check_bit({name, " rx ready set"}, 1'b1, word[STAT_RX_BIT]);
      bus_cycle(1'b0, ADDR_DATA, t_sel[i], '0, rdata);
      check_word({name, " rx data"}, t_exp[i], rdata);
      read_status(word, pins);
      check_bit({name, " rx ready clear"}, 1'b0, word[STAT_RX_BIT]);
      check_byte({name, " mosi byte"}, t_dat[i][BYTE_W-1:0], slv_rx);
      @(negedge clk);
      check_bit({name, " sclk idle"}, conf_model[CONF_CPOL_BIT], sclk);
    end else begin
      report_failure({"Unknown operation in data file for test ", name});
    end
  endtask

  // Run limit scales with the number of tests
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      report_failure($sformatf("Timeout: run exceeded %0d cycles", cycle_limit));
    end
  end

  initial begin
    rst        = 1'b1;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    adr        = 1'b0;
    sel        = '0;
    dat_wr     = '0;
    codec_irq  = 1'b0;
    wp         = 1'b0;
    slv_load   = 1'b0;
    slv_reply  = '0;
    slv_cpol   = 1'b0;
    slv_cpha   = 1'b0;
    conf_model = '0;
    load_tests();
    cycle_limit = t_name.size() * CYCLES_PER_TEST;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < t_name.size(); i++) begin
      run_test(i);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

// File: spi_input.txt
# name op(W write, R read, X transfer, B write while busy) adr sel data reply expected
# expected: W selects_o byte, R read word without irq/wp bits, X and B received byte
reset_status R 1 F 00000000 00 FF000000
lane3_only W 1 8 FE123456 00 000000FE
lane2_only W 1 4 AB040000 00 000000FE
lane_check R 1 F 00000000 00 FE040000
all_lanes W 1 F 7F000000 00 0000007F
no_lanes W 1 0 00FF0000 00 0000007F
lanes_kept R 1 F 00000000 00 7F000000
mode0_cfg W 1 C 7E000000 00 0000007E
mode0_fast X 0 F 000000A5 3C 0000003C
mode1_cfg W 1 4 00090000 00 0000007E
mode1_slow X 0 F 0000005A C3 000000C3
mode2_cfg W 1 4 00040000 00 0000007E
mode2_fast X 0 F 00000096 69 00000069
mode3_cfg W 1 4 000D0000 00 0000007E
mode3_slow X 0 F 0000000F F0 000000F0
write_busy B 0 F 00000055 AA 000000AA
mode0s_cfg W 1 4 00010000 00 0000007E
mode0_slow X 0 F 000000C6 81 00000081
final_status R 1 F 00000000 00 7E010000

// File: compile.f
spi_pkg.sv
spi_clk_div.sv
spi_xcvr.sv
spi_master.sv
spi_top.sv
tb_spi_slave.sv
tb_spi_top.sv
